//--- src/rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int MEM_WORDS  = 256;
  localparam int MEM_ADDR_W = 8;                  // byte addr bits 9:2

  // memory map, byte addresses
  localparam logic [XLEN-1:0] PROG_BASE  = 32'd0;
  localparam logic [XLEN-1:0] PROG_LIMIT = 32'd511;
  localparam logic [XLEN-1:0] DATA_BASE  = 32'd512;
  localparam logic [XLEN-1:0] DATA_LIMIT = 32'd1020; // last data word

  localparam logic [REG_ADDR_W-1:0] HALT_REG  = 5'd17; // a7 holds the exit code
  localparam logic [XLEN-1:0]       HALT_CODE = 32'd10;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic       F7_SUB     = 1'b1;       // inst[30]

endpackage

//--- src/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;
  import rv_pkg::*;

  logic            req;                           // held until gnt
  logic            we;
  logic [XLEN-1:0] addr;                          // byte address
  logic [XLEN-1:0] wdata;
  logic            gnt;                           // request completes this cycle
  logic [XLEN-1:0] rdata;
  logic            rvalid;                        // one cycle after a read gnt

  modport requester (output req, we, addr, wdata, input gnt, rdata, rvalid);
  modport arbiter (input req, we, addr, wdata, output gnt, rdata, rvalid);

endinterface

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                          clk,
  input  logic                          reset,
  mem_bus_if.arbiter                    fetch_bus,
  mem_bus_if.arbiter                    data_bus,
  input  logic                          host_req,
  input  logic                          host_we,
  input  logic [rv_pkg::XLEN-1:0]       host_addr,
  input  logic [rv_pkg::XLEN-1:0]       host_wdata,
  output logic                          host_gnt,
  output logic                          host_rvalid,
  output logic [rv_pkg::XLEN-1:0]       host_rdata,
  output logic                          mem_en,
  output logic                          mem_we,
  output logic [rv_pkg::MEM_ADDR_W-1:0] mem_addr,
  output logic [rv_pkg::XLEN-1:0]       mem_wdata,
  input  logic [rv_pkg::XLEN-1:0]       mem_rdata
);
  import rv_pkg::*;

  logic [XLEN-1:0] sel_addr;                      // byte addr of the winner
  logic            rd_host_q;                     // read winner of last cycle
  logic            rd_data_q;
  logic            rd_fetch_q;

  // fixed priority: host > data > fetch
  assign host_gnt      = host_req;
  assign data_bus.gnt  = data_bus.req & ~host_req;
  assign fetch_bus.gnt = fetch_bus.req & ~host_req & ~data_bus.req;

  always_comb begin
    sel_addr  = fetch_bus.addr;                   // fetch is the fallback
    mem_we    = fetch_bus.gnt & fetch_bus.we;
    mem_wdata = fetch_bus.wdata;
    if (host_gnt) begin
      sel_addr  = host_addr;
      mem_we    = host_we;
      mem_wdata = host_wdata;
    end else if (data_bus.gnt) begin
      sel_addr  = data_bus.addr;
      mem_we    = data_bus.we;
      mem_wdata = data_bus.wdata;
    end
  end

  assign mem_en   = host_gnt | data_bus.gnt | fetch_bus.gnt;
  assign mem_addr = sel_addr[MEM_ADDR_W+1:2];     // word select

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_host_q  <= 1'b0;
      rd_data_q  <= 1'b0;
      rd_fetch_q <= 1'b0;
    end else begin
      rd_host_q  <= host_gnt & ~host_we;
      rd_data_q  <= data_bus.gnt & ~data_bus.we;
      rd_fetch_q <= fetch_bus.gnt & ~fetch_bus.we;
    end
  end

  // read data goes back only to the requester that won
  assign host_rvalid      = rd_host_q;
  assign data_bus.rvalid  = rd_data_q;
  assign fetch_bus.rvalid = rd_fetch_q;
  assign host_rdata       = rd_host_q ? mem_rdata : '0;
  assign data_bus.rdata   = rd_data_q ? mem_rdata : '0;
  assign fetch_bus.rdata  = rd_fetch_q ? mem_rdata : '0;

  // data requester holds its fields while host traffic blocks it
  data_req_stable: assert property (@(posedge clk) disable iff (reset)
    (data_bus.req && !data_bus.gnt) |=> (data_bus.req && $stable(data_bus.addr)
                                         && $stable(data_bus.we) && $stable(data_bus.wdata)));

endmodule

//--- src/unified_memory.sv
`timescale 1ns/1ps

module unified_memory (
  input  logic                          clk,
  input  logic                          mem_en,
  input  logic                          mem_we,
  input  logic [rv_pkg::MEM_ADDR_W-1:0] mem_addr,
  input  logic [rv_pkg::XLEN-1:0]       mem_wdata,
  output logic [rv_pkg::XLEN-1:0]       mem_rdata
);
  import rv_pkg::*;

  logic [XLEN-1:0] mem [MEM_WORDS];               // program and data share it

  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end else begin
        mem_rdata <= mem[mem_addr];               // valid the next cycle
      end
    end
  end

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    run,
  mem_bus_if.requester            bus,
  output logic [rv_pkg::XLEN-1:0] inst,
  output logic [rv_pkg::XLEN-1:0] inst_pc,
  output logic                    inst_valid,
  input  logic                    inst_take,
  input  logic                    redirect,
  input  logic                    halted,
  input  logic [rv_pkg::XLEN-1:0] redirect_pc
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc;                            // next address to fetch
  logic [XLEN-1:0] req_pc;                        // pc of the read in flight
  logic            pending;                       // granted, rvalid not yet seen
  logic            slot_free;
  logic            accept;

  assign slot_free = ~inst_valid | inst_take;
  // always predict not-taken, a redirect cycle issues nothing
  assign bus.req   = run & ~halted & ~redirect & ~pending & slot_free;
  assign bus.we    = 1'b0;
  assign bus.addr  = pc;
  assign bus.wdata = '0;
  assign accept    = bus.rvalid & ~redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= '0;
      pending    <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      if (redirect) pc <= redirect_pc;
      else if (bus.req && bus.gnt) pc <= pc + XLEN'(4);
      if (bus.req && bus.gnt) pending <= 1'b1;
      else if (bus.rvalid) pending <= 1'b0;
      // no read in flight while an inst is held, so nothing stale to drop
      if (redirect) inst_valid <= 1'b0;           // flush held inst
      else if (accept) inst_valid <= 1'b1;
      else if (inst_take) inst_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req && bus.gnt) req_pc <= pc;
    if (accept) begin
      inst    <= bus.rdata;
      inst_pc <= req_pc;
    end
  end

  fetch_req_stable: assert property (@(posedge clk) disable iff (reset)
    (bus.req && !bus.gnt) |=> (bus.req && $stable(bus.addr) && $stable(bus.we)
                               && $stable(bus.wdata)));

endmodule

//--- src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rv_pkg::XLEN-1:0]       inst,
  input  logic [rv_pkg::XLEN-1:0]       inst_pc,
  input  logic                          inst_valid,
  output logic                          inst_take,
  output logic                          redirect,
  output logic                          halted,
  output logic [rv_pkg::XLEN-1:0]       redirect_pc,
  mem_bus_if.requester                  bus,
  input  logic [rv_pkg::REG_ADDR_W-1:0] dbg_reg_addr,
  output logic [rv_pkg::XLEN-1:0]       dbg_reg_data
);
  import rv_pkg::*;

  logic [XLEN-1:0]       regs [NUM_REGS];         // x0 cleared at reset, never written
  opcode_e               opcode;
  alu_op_e               alu_op;
  logic [2:0]            funct3;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1_idx;
  logic [REG_ADDR_W-1:0] rs2_idx;
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_s;
  logic [XLEN-1:0]       imm_b;
  logic [XLEN-1:0]       imm_j;
  logic [XLEN-1:0]       alu_b;
  logic [XLEN-1:0]       alu_result;
  logic [XLEN-1:0]       rd_wdata;
  logic                  is_load;
  logic                  is_store;
  logic                  is_ecall;
  logic                  br_taken;
  logic                  mem_done;
  logic                  valid_eff;
  logic                  reg_we;
  logic                  load_wait;               // load granted, data pending
  logic                  halt_q;
  logic                  halt_now;

  assign opcode   = opcode_e'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign rd       = inst[11:7];
  assign rs2_idx  = inst[24:20];
  assign rs1_idx  = (opcode == opc_system) ? HALT_REG : inst[19:15]; // ecall looks at a7
  assign is_load  = (opcode == opc_load) && (funct3 == F3_LW);
  assign is_store = (opcode == opc_store) && (funct3 == F3_SW);
  assign is_ecall = (opcode == opc_system) && (inst[31:7] == '0);

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign rs1_val      = regs[rs1_idx];
  assign rs2_val      = regs[rs2_idx];
  assign dbg_reg_data = regs[dbg_reg_addr];

  // op/op_imm pick by funct3, everything else adds (address calc)
  always_comb begin
    alu_op = alu_add;
    if (opcode == opc_op || opcode == opc_op_imm) begin
      case (funct3)
        F3_ADD_SUB: alu_op = (opcode == opc_op && inst[30] == F7_SUB) ? alu_sub : alu_add;
        F3_SLT:     alu_op = alu_slt;
        F3_XOR:     alu_op = alu_xor;
        F3_OR:      alu_op = alu_or;
        F3_AND:     alu_op = alu_and;
        default:    alu_op = alu_add;               // shifts not supported
      endcase
    end
  end

  assign alu_b = (opcode == opc_op) ? rs2_val : (is_store ? imm_s : imm_i);

  always_comb begin
    case (alu_op)
      alu_sub: alu_result = rs1_val - alu_b;
      alu_and: alu_result = rs1_val & alu_b;
      alu_or:  alu_result = rs1_val | alu_b;
      alu_xor: alu_result = rs1_val ^ alu_b;
      alu_slt: alu_result = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(alu_b)};
      default: alu_result = rs1_val + alu_b;
    endcase
  end

  always_comb begin
    br_taken = 1'b0;
    if (opcode == opc_branch) begin
      if (funct3 == F3_BEQ) br_taken = (rs1_val == rs2_val);
      else if (funct3 == F3_BNE) br_taken = (rs1_val != rs2_val);
    end
  end

  // data side: req held while the load/store sits in the slot
  assign valid_eff = inst_valid & ~halt_q;
  assign bus.req   = valid_eff & (is_load | is_store) & ~load_wait;
  assign bus.we    = is_store;
  assign bus.addr  = alu_result;
  assign bus.wdata = rs2_val;
  assign mem_done  = is_store ? bus.gnt : (load_wait & bus.rvalid);

  assign inst_take   = valid_eff & ((is_load | is_store) ? mem_done : 1'b1);
  assign redirect    = inst_take & ((opcode == opc_jal) | br_taken);
  assign redirect_pc = inst_pc + ((opcode == opc_jal) ? imm_j : imm_b);
  assign halt_now    = inst_take & is_ecall & (rs1_val == HALT_CODE);
  assign halted      = halt_q | halt_now;       // high in the retire cycle

  assign reg_we = inst_take & (rd != '0)
                & (opcode == opc_op || opcode == opc_op_imm || opcode == opc_jal || is_load);

  always_comb begin
    if (is_load) rd_wdata = bus.rdata;
    else if (opcode == opc_jal) rd_wdata = inst_pc + XLEN'(4); // link
    else rd_wdata = alu_result;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load_wait <= 1'b0;
      halt_q    <= 1'b0;
    end else begin
      if (is_load && bus.req && bus.gnt) load_wait <= 1'b1;
      else if (bus.rvalid) load_wait <= 1'b0;
      if (halt_now) halt_q <= 1'b1;               // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    if (reset) regs[0] <= '0;                     // x0 holds zero from here on
    else if (reg_we) regs[rd] <= rd_wdata;
  end

  x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    regs[0] == '0);

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          host_req,
  input  logic                          host_we,
  input  logic [rv_pkg::XLEN-1:0]       host_addr,
  input  logic [rv_pkg::XLEN-1:0]       host_wdata,
  output logic                          host_gnt,
  output logic [rv_pkg::XLEN-1:0]       host_rdata,
  output logic                          host_rvalid,
  input  logic [rv_pkg::REG_ADDR_W-1:0] dbg_reg_addr,
  output logic [rv_pkg::XLEN-1:0]       dbg_reg_data,
  output logic                          is_halted
);
  import rv_pkg::*;

  logic [XLEN-1:0]       inst;                    // fetch -> exec
  logic [XLEN-1:0]       inst_pc;
  logic                  inst_valid;
  logic                  inst_take;               // exec -> fetch
  logic                  redirect;
  logic [XLEN-1:0]       redirect_pc;
  logic                  mem_en;                  // arbiter -> memory
  logic                  mem_we;
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic [XLEN-1:0]       mem_wdata;
  logic [XLEN-1:0]       mem_rdata;

  mem_bus_if fetch_bus ();
  mem_bus_if data_bus ();

  fetch_unit fetch_unit_i (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .bus         (fetch_bus.requester),
    .inst        (inst),
    .inst_pc     (inst_pc),
    .inst_valid  (inst_valid),
    .inst_take   (inst_take),
    .redirect    (redirect),
    .halted      (is_halted),
    .redirect_pc (redirect_pc)
  );

  exec_unit exec_unit_i (
    .clk          (clk),
    .reset        (reset),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .inst_valid   (inst_valid),
    .inst_take    (inst_take),
    .redirect     (redirect),
    .halted       (is_halted),                    // also stops fetch
    .redirect_pc  (redirect_pc),
    .bus          (data_bus.requester),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data)
  );

  mem_arbiter mem_arbiter_i (
    .clk         (clk),
    .reset       (reset),
    .fetch_bus   (fetch_bus.arbiter),
    .data_bus    (data_bus.arbiter),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .mem_en      (mem_en),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata)
  );

  unified_memory unified_memory_i (
    .clk       (clk),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int HOST_TIMEOUT = 20;               // cycles until host gnt
  localparam int HALT_TIMEOUT = 4000;             // cycles until is_halted
  localparam int NUM_PROGS    = 4;

  logic                  clk;
  logic                  reset;
  logic                  run;
  logic                  host_req;
  logic                  host_we;
  logic [XLEN-1:0]       host_addr;
  logic [XLEN-1:0]       host_wdata;
  logic                  host_gnt;
  logic [XLEN-1:0]       host_rdata;
  logic                  host_rvalid;
  logic [REG_ADDR_W-1:0] dbg_reg_addr;
  logic [XLEN-1:0]       dbg_reg_data;
  logic                  is_halted;

  logic [31:0] lcg_state;
  logic [31:0] m_mem [MEM_WORDS];                 // image, then model memory
  logic [31:0] m_reg [NUM_REGS];                  // model register file

  rv_core_top rv_core_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16] % n;                  // upper bits, low ones are weak
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping on first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping on timeout");
  endtask

  // rv32i encoders
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {1'b0, f7, 5'b0, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // prologue sets x1..x15 and x17, random body, then li x17 10, ecall, dead sw
  task automatic gen_program();
    int          body_end;
    int          kind;
    int          k;
    int          off;
    int unsigned n;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    for (int i = 0; i < MEM_WORDS; i++)
      m_mem[i] = (i * 32'h9e3779b9) ^ 32'h13572468;  // fill spreads over the whole address
    for (int r = 1; r < 16; r++)
      m_mem[r-1] = enc_i(12'(rand_below(4096)), 5'd0, 3'b000, 5'(r), 7'h13);
    m_mem[15] = enc_i(12'd3, 5'd0, 3'b000, 5'd17, 7'h13);  // not the exit code yet
    body_end = 16 + rand_below(60) + 40;
    for (int j = 16; j < body_end; j++) begin
      kind = rand_below(10);
      rd   = 5'(rand_below(16));
      rs1  = 5'(rand_below(16));
      rs2  = (rand_below(2) == 1) ? rs1 : 5'(rand_below(16));  // equal regs, beq taken
      imm  = 12'(rand_below(4096));
      n    = rand_below(5);
      f3   = (n == 4) ? 3'd7 : 3'(2 * n);
      k    = 2 + rand_below(4);                   // forward only
      if (j + k > body_end)
        k = body_end - j;                         // land on li x17 at the latest
      off  = 512 + 4 * rand_below(128);           // data word byte address
      case (kind)
        0, 1, 2, 3: m_mem[j] = enc_r(1'(rand_below(2)), rs2, rs1, f3, rd);
        4, 5:       m_mem[j] = enc_i(imm, rs1, f3, rd, 7'h13);
        6:          m_mem[j] = enc_i(12'(off), 5'd0, 3'b010, rd, 7'h03);
        7:          m_mem[j] = enc_s(12'(off), rs2, 5'd0);
        8:          m_mem[j] = enc_b(13'(4 * k), rs2, rs1, {2'b00, 1'(rand_below(2))});
        default:    m_mem[j] = enc_j(21'(4 * k), rd);
      endcase
    end
    m_mem[body_end]     = enc_i(12'd10, 5'd0, 3'b000, 5'd17, 7'h13);
    m_mem[body_end + 1] = 32'h0000_0073;          // ecall
    m_mem[body_end + 2] = enc_s(12'(512 + 4 * rand_below(128)), 5'(1 + rand_below(15)), 5'd0);
  endtask

  task automatic model_run();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] nxt;
    logic [4:0]  rd;
    logic        done;
    int          steps;
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done) begin
      ins = m_mem[pc[9:2]];
      rd  = ins[11:7];
      a   = m_reg[ins[19:15]];
      b   = m_reg[ins[24:20]];
      nxt = pc + 32'd4;
      case (ins[6:0])
        7'h33: m_reg[rd] = alu_ref(ins[14:12], ins[30], a, b);
        7'h13: m_reg[rd] = alu_ref(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
        7'h03: begin
          ea = a + {{20{ins[31]}}, ins[31:20]};
          m_reg[rd] = m_mem[ea[9:2]];
        end
        7'h23: begin
          ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          m_mem[ea[9:2]] = b;
        end
        7'h63: begin
          if (ins[12] ? (a != b) : (a == b))      // bne : beq
            nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        7'h6f: begin
          m_reg[rd] = pc + 32'd4;                 // link
          nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h73: done = (m_reg[17] == 32'd10);
        default: ;
      endcase
      m_reg[0] = '0;
      pc = nxt;
      steps++;
      if (steps > 200 && !done)
        report_timeout("model program never reached the halting ecall");
    end
  endtask

  // one host request, held until gnt, read data one cycle after gnt
  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    n = 0;
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    @(negedge clk);
    while (host_gnt !== 1'b1) begin
      n++;
      if (n > HOST_TIMEOUT)
        report_timeout("host request was never granted");
      @(negedge clk);
    end
    check_value("host_rvalid", 32'd0, 32'(host_rvalid));  // not yet in gnt cycle
    @(posedge clk);
    host_req <= 1'b0;
    rdata = '0;
    if (we == 1'b0) begin
      @(negedge clk);
      check_value("host_rvalid", 32'd1, 32'(host_rvalid));
      rdata = host_rdata;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    run   <= 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (4) begin                              // idle, no request anywhere
      @(negedge clk);
      check_value("is_halted", 32'd0, 32'(is_halted));
      check_value("host_gnt", 32'd0, 32'(host_gnt));
      check_value("host_rvalid", 32'd0, 32'(host_rvalid));
    end
  endtask

  initial begin
    logic [31:0] rd_word;
    int          n;
    lcg_state    = 32'h8b2726ca;
    reset        = 1'b1;
    run          = 1'b0;
    host_req     = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    dbg_reg_addr = '0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      apply_reset();
      gen_program();
      for (int w = 0; w < MEM_WORDS; w++)
        host_access(1'b1, 32'(4 * w), m_mem[w], rd_word);
      for (int w = 0; w < MEM_WORDS; w++) begin  // read back whole image
        host_access(1'b0, 32'(4 * w), '0, rd_word);
        check_value($sformatf("host_rdata @%0d", 4 * w), m_mem[w], rd_word);
      end
      for (int r = 0; r < NUM_REGS; r++)
        m_reg[r] = '0;
      model_run();
      @(posedge clk);
      dbg_reg_addr <= HALT_REG;                   // watch a7 while running
      run          <= 1'b1;
      n = 0;
      @(negedge clk);
      while (is_halted !== 1'b1) begin
        n++;
        if (n > HALT_TIMEOUT)
          report_timeout("core did not halt on the closing ecall");
        @(negedge clk);
      end
      check_value("x17 at halt", HALT_CODE, dbg_reg_data);
      @(posedge clk);
      run <= 1'b0;
      for (int r = 0; r < 18; r++) begin
        if (r != 16) begin                        // x16 never written
          @(posedge clk);
          dbg_reg_addr <= 5'(r);
          @(negedge clk);
          check_value($sformatf("x%0d", r), m_reg[r], dbg_reg_data);
          check_value("is_halted", 32'd1, 32'(is_halted));
        end
      end
      for (int w = DATA_BASE / 4; w < MEM_WORDS; w++) begin
        host_access(1'b0, 32'(4 * w), '0, rd_word);
        check_value($sformatf("mem @%0d", 4 * w), m_mem[w], rd_word);
      end
      check_value("is_halted", 32'd1, 32'(is_halted));  // still sticky
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- flist.f
src/rv_pkg.sv
src/mem_bus_if.sv
src/mem_arbiter.sv
src/unified_memory.sv
src/fetch_unit.sv
src/exec_unit.sv
src/rv_core_top.sv
verif/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_rv_core -f flist.f
out=$(./obj_dir/Vtb_rv_core || true)
echo "$out"
if grep -q "SIMULATION PASSED" <<< "$out"; then
  exit 0
fi
exit 1
